/* rtl/exu_params.svh */
`ifndef EXU_PARAMS_SVH
`define EXU_PARAMS_SVH

// datapath and pc width
`define EXU_XLEN 64

// architectural register index width
`define EXU_REG_AW 5

// sequential pc step, 32-bit encodings only
`define EXU_INST_BYTES 4

// result of slt/sltu is one bit zero extended
`define EXU_FLAG_PAD (`EXU_XLEN - 1)

// shift amount width for rv64
`define EXU_SHAMT_W 6

`endif

/* rtl/exu_pkg.sv */
`default_nettype none

`include "exu_params.svh"

package exu_pkg;

    // decoded instruction class from ID
    typedef enum logic [2:0] {
        OP_LUI     = 3'd0,
        OP_AUIPC   = 3'd1,
        OP_JAL     = 3'd2,
        OP_JALR    = 3'd3,
        OP_BRANCH  = 3'd4,
        OP_ALU_REG = 3'd5,
        OP_ALU_IMM = 3'd6,
        OP_NONE    = 3'd7
    } op_class_t;

    // alu function, derived in EX from funct3 and alt
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_op_t;

    typedef logic [`EXU_XLEN-1:0] xword_t;
    typedef logic [`EXU_REG_AW-1:0] reg_addr_t;

    // one slot of the ID/EX register
    typedef struct packed {
        xword_t    pc;
        op_class_t op_class;
        logic [2:0] funct3;
        // funct7 bit 5
        logic      alt;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        // register file values read in ID
        xword_t    src_a;
        xword_t    src_b;
        xword_t    imm;
    } ex_entry_t;

endpackage

`default_nettype wire

/* rtl/exu_bypass_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface exu_bypass_if;

    // MEM stage writeback in flight
    logic               mem_wen;
    exu_pkg::reg_addr_t mem_rd;
    exu_pkg::xword_t    mem_data;

    // WB stage writeback in flight
    logic               wb_wen;
    exu_pkg::reg_addr_t wb_rd;
    exu_pkg::xword_t    wb_data;

    // top level drives from its ports
    modport source (
        output mem_wen, mem_rd, mem_data,
        output wb_wen, wb_rd, wb_data
    );

    // forwarding mux only looks, no handshake
    modport sink (
        input mem_wen, mem_rd, mem_data,
        input wb_wen, wb_rd, wb_data
    );

endinterface

`default_nettype wire

/* rtl/ex_stage_reg.sv */
`timescale 1ns/100ps
`default_nettype none

module ex_stage_reg (
    input  var logic                clk,
    input  var logic                reset,
    input  var logic                flush,
    input  var logic                valid_in,
    input  var logic                ready_in,
    input  var exu_pkg::ex_entry_t  entry_in,
    output var logic                valid,
    output var exu_pkg::ex_entry_t  entry
);

    // valid bit of the single EX slot
    // flush wins over hold, a squashed slot must not leak downstream
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            valid <= 1'b0;
        end else if (ready_in) begin
            valid <= valid_in;
        end
    end

    // payload
    // only qualified by valid, so no clear needed
    // stall keeps every field as is
    always_ff @(posedge clk) begin
        if (ready_in) begin
            entry <= entry_in;
        end
    end

endmodule

`default_nettype wire

/* rtl/operand_bypass.sv */
`timescale 1ns/100ps
`default_nettype none

module operand_bypass (
    input  var exu_pkg::ex_entry_t entry,
    exu_bypass_if.sink             byp,
    output var exu_pkg::xword_t    op_a,
    output var exu_pkg::xword_t    op_b
);

    logic rs2_used;
    logic rs1_mem_hit;
    logic rs1_wb_hit;
    logic rs2_mem_hit;
    logic rs2_wb_hit;

    // immediate forms carry garbage in rs2, keep it out of the match
    assign rs2_used = (entry.op_class == exu_pkg::OP_ALU_REG) ||
                      (entry.op_class == exu_pkg::OP_BRANCH);

    // x0 reads as zero, never take a forwarded value for it
    assign rs1_mem_hit = byp.mem_wen && (byp.mem_rd == entry.rs1) &&
                         (entry.rs1 != '0);
    assign rs1_wb_hit  = byp.wb_wen && (byp.wb_rd == entry.rs1) &&
                         (entry.rs1 != '0);
    assign rs2_mem_hit = rs2_used && byp.mem_wen && (byp.mem_rd == entry.rs2) &&
                         (entry.rs2 != '0);
    assign rs2_wb_hit  = rs2_used && byp.wb_wen && (byp.wb_rd == entry.rs2) &&
                         (entry.rs2 != '0);

    // MEM is younger than WB, so it takes priority
    always_comb begin
        if (rs1_mem_hit) begin
            op_a = byp.mem_data;
        end else if (rs1_wb_hit) begin
            op_a = byp.wb_data;
        end else begin
            op_a = entry.src_a;
        end
    end

    always_comb begin
        if (rs2_mem_hit) begin
            op_b = byp.mem_data;
        end else if (rs2_wb_hit) begin
            op_b = byp.wb_data;
        end else begin
            op_b = entry.src_b;
        end
    end

endmodule

`default_nettype wire

/* rtl/alu_core.sv */
`timescale 1ns/100ps
`default_nettype none

`include "exu_params.svh"

module alu_core (
    input  var exu_pkg::ex_entry_t entry,
    input  var exu_pkg::xword_t    op_a,
    input  var exu_pkg::xword_t    op_b,
    output var exu_pkg::xword_t    result
);

    exu_pkg::alu_op_t        alu_op;
    exu_pkg::xword_t         alu_a;
    exu_pkg::xword_t         alu_b;
    logic [`EXU_SHAMT_W-1:0] shamt;
    logic                    is_alu;

    assign is_alu = (entry.op_class == exu_pkg::OP_ALU_REG) ||
                    (entry.op_class == exu_pkg::OP_ALU_IMM);

    // funct3/alt decode
    // non-alu classes just add their operands
    always_comb begin
        alu_op = exu_pkg::ALU_ADD;
        if (is_alu) begin
            case (entry.funct3)
                // addi has no sub form, imm[10] lands in alt
                3'd0: alu_op = (entry.alt && entry.op_class == exu_pkg::OP_ALU_REG) ?
                               exu_pkg::ALU_SUB : exu_pkg::ALU_ADD;
                3'd1: alu_op = exu_pkg::ALU_SLL;
                3'd2: alu_op = exu_pkg::ALU_SLT;
                3'd3: alu_op = exu_pkg::ALU_SLTU;
                3'd4: alu_op = exu_pkg::ALU_XOR;
                // srai and sra both use alt
                3'd5: alu_op = entry.alt ? exu_pkg::ALU_SRA : exu_pkg::ALU_SRL;
                3'd6: alu_op = exu_pkg::ALU_OR;
                default: alu_op = exu_pkg::ALU_AND;
            endcase
        end
    end

    // first operand
    always_comb begin
        case (entry.op_class)
            exu_pkg::OP_LUI:   alu_a = '0;
            exu_pkg::OP_AUIPC,
            exu_pkg::OP_JAL,
            exu_pkg::OP_JALR:  alu_a = entry.pc;
            default:           alu_a = op_a;
        endcase
    end

    // second operand
    // jumps write back the return address
    always_comb begin
        case (entry.op_class)
            exu_pkg::OP_LUI,
            exu_pkg::OP_AUIPC,
            exu_pkg::OP_ALU_IMM: alu_b = entry.imm;
            exu_pkg::OP_JAL,
            exu_pkg::OP_JALR:    alu_b = exu_pkg::xword_t'(`EXU_INST_BYTES);
            default:             alu_b = op_b;
        endcase
    end

    // rv64 shifts use 6 bits
    assign shamt = alu_b[`EXU_SHAMT_W-1:0];

    always_comb begin
        case (alu_op)
            exu_pkg::ALU_SUB:  result = alu_a - alu_b;
            exu_pkg::ALU_SLL:  result = alu_a << shamt;
            exu_pkg::ALU_SLT:  result = {{`EXU_FLAG_PAD{1'b0}}, $signed(alu_a) < $signed(alu_b)};
            exu_pkg::ALU_SLTU: result = {{`EXU_FLAG_PAD{1'b0}}, alu_a < alu_b};
            exu_pkg::ALU_XOR:  result = alu_a ^ alu_b;
            exu_pkg::ALU_SRL:  result = alu_a >> shamt;
            exu_pkg::ALU_SRA:  result = exu_pkg::xword_t'($signed(alu_a) >>> shamt);
            exu_pkg::ALU_OR:   result = alu_a | alu_b;
            exu_pkg::ALU_AND:  result = alu_a & alu_b;
            default:           result = alu_a + alu_b;
        endcase
        // branches write no register
        if (entry.op_class == exu_pkg::OP_BRANCH) begin
            result = '0;
        end
    end

endmodule

`default_nettype wire

/* rtl/branch_resolve.sv */
`timescale 1ns/100ps
`default_nettype none

`include "exu_params.svh"

module branch_resolve (
    input  var exu_pkg::ex_entry_t entry,
    input  var exu_pkg::xword_t    op_a,
    input  var exu_pkg::xword_t    op_b,
    input  var logic               valid,
    input  var logic               ready_out,
    output var logic               pc_update,
    output var exu_pkg::xword_t    dnpc
);

    exu_pkg::xword_t jalr_sum;
    logic            taken;
    logic            is_jump;
    logic            is_branch;

    assign is_jump   = (entry.op_class == exu_pkg::OP_JAL) ||
                       (entry.op_class == exu_pkg::OP_JALR);
    assign is_branch = entry.op_class == exu_pkg::OP_BRANCH;

    // branch condition, funct3 2 and 3 are not defined
    always_comb begin
        case (entry.funct3)
            3'd0: taken = op_a == op_b;
            3'd1: taken = op_a != op_b;
            3'd4: taken = $signed(op_a) < $signed(op_b);
            3'd5: taken = $signed(op_a) >= $signed(op_b);
            3'd6: taken = op_a < op_b;
            3'd7: taken = op_a >= op_b;
            default: taken = 1'b0;
        endcase
    end

    // register-relative target
    assign jalr_sum = op_a + entry.imm;

    // resolved target, no prediction
    always_comb begin
        case (entry.op_class)
            exu_pkg::OP_JAL,
            exu_pkg::OP_BRANCH: dnpc = entry.pc + entry.imm;
            // lsb forced low per spec
            exu_pkg::OP_JALR:   dnpc = {jalr_sum[`EXU_XLEN-1:1], 1'b0};
            default:            dnpc = entry.pc + exu_pkg::xword_t'(`EXU_INST_BYTES);
        endcase
    end

    // redirect fetch only when the entry actually leaves EX
    assign pc_update = valid && ready_out && (is_jump || (is_branch && taken));

endmodule

`default_nettype wire

/* rtl/exu_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module exu_stage (
    input  var logic                  clk,
    input  var logic                  reset,
    input  var logic                  flush,
    // from ID
    input  var logic                  valid_in,
    output var logic                  ready_in,
    input  var exu_pkg::xword_t       pc_in,
    input  var exu_pkg::op_class_t    op_class_in,
    input  var logic [2:0]            funct3_in,
    input  var logic                  alt_in,
    input  var exu_pkg::reg_addr_t    rd_in,
    input  var exu_pkg::reg_addr_t    rs1_in,
    input  var exu_pkg::reg_addr_t    rs2_in,
    input  var exu_pkg::xword_t       src_a_in,
    input  var exu_pkg::xword_t       src_b_in,
    input  var exu_pkg::xword_t       imm_in,
    // to MEM
    output var logic                  valid_out,
    input  var logic                  ready_out,
    output var exu_pkg::xword_t       pc_out,
    output var exu_pkg::reg_addr_t    rd_out,
    output var exu_pkg::xword_t       result,
    // forwarding sources
    input  var logic                  mem_wen,
    input  var exu_pkg::reg_addr_t    mem_rd,
    input  var exu_pkg::xword_t       mem_data,
    input  var logic                  wb_wen,
    input  var exu_pkg::reg_addr_t    wb_rd,
    input  var exu_pkg::xword_t       wb_data,
    // fetch redirect
    output var logic                  pc_update,
    output var exu_pkg::xword_t       dnpc
);

    exu_pkg::ex_entry_t entry_in;
    exu_pkg::ex_entry_t entry;
    exu_pkg::xword_t    op_a;
    exu_pkg::xword_t    op_b;

    exu_bypass_if byp ();

    assign byp.mem_wen  = mem_wen;
    assign byp.mem_rd   = mem_rd;
    assign byp.mem_data = mem_data;
    assign byp.wb_wen   = wb_wen;
    assign byp.wb_rd    = wb_rd;
    assign byp.wb_data  = wb_data;

    assign entry_in = '{pc: pc_in, op_class: op_class_in, funct3: funct3_in,
                        alt: alt_in, rd: rd_in, rs1: rs1_in, rs2: rs2_in,
                        src_a: src_a_in, src_b: src_b_in, imm: imm_in};

    // single-cycle units only, so EX stalls exactly when MEM does
    assign ready_in = ready_out;

    ex_stage_reg u_ex_stage_reg (
        .clk      (clk),
        .reset    (reset),
        .flush    (flush),
        .valid_in (valid_in),
        .ready_in (ready_in),
        .entry_in (entry_in),
        .valid    (valid_out),
        .entry    (entry)
    );

    operand_bypass u_operand_bypass (.entry(entry), .byp(byp), .op_a(op_a), .op_b(op_b));

    alu_core u_alu_core (.entry(entry), .op_a(op_a), .op_b(op_b), .result(result));

    branch_resolve u_branch_resolve (
        .entry     (entry),
        .op_a      (op_a),
        .op_b      (op_b),
        .valid     (valid_out),
        .ready_out (ready_out),
        .pc_update (pc_update),
        .dnpc      (dnpc)
    );

    // MEM side payload straight from the slot
    assign pc_out = entry.pc;
    assign rd_out = entry.rd;

endmodule

`default_nettype wire

/* testbench/exu_assertions.sv */
`timescale 1ns/100ps
`default_nettype none

module exu_assertions (
    input var logic               clk,
    input var logic               reset,
    input var logic               flush,
    input var logic               ready_in,
    input var logic               valid_out,
    input var logic               ready_out,
    input var exu_pkg::xword_t    pc_out,
    input var exu_pkg::reg_addr_t rd_out,
    input var logic               pc_update
);

    // failure tally, read by the testbench summary
    int failures = 0;

    // cleared slot, nothing valid in the following cycle
    a_clear: assert property (@(posedge clk) (reset || flush) |=> !valid_out)
        else begin
            failures++;
            $error("valid_out high in the cycle after reset or flush");
        end

    // redirect only when the entry leaves EX
    a_redirect: assert property (@(posedge clk) pc_update |-> (valid_out && ready_out))
        else begin
            failures++;
            $error("pc_update without valid_out and ready_out");
        end

    // stalled entry keeps its payload
    a_hold: assert property (@(posedge clk) disable iff (reset)
        (valid_out && !ready_out && !flush) |=>
            (valid_out && $stable(pc_out) && $stable(rd_out)))
        else begin
            failures++;
            $error("EX output changed during back-pressure");
        end

    // no blocking unit inside
    a_ready: assert property (@(posedge clk) ready_in == ready_out)
        else begin
            failures++;
            $error("ready_in differs from ready_out");
        end

endmodule

bind exu_stage exu_assertions u_exu_assertions (
    .clk       (clk),
    .reset     (reset),
    .flush     (flush),
    .ready_in  (ready_in),
    .valid_out (valid_out),
    .ready_out (ready_out),
    .pc_out    (pc_out),
    .rd_out    (rd_out),
    .pc_update (pc_update)
);

`default_nettype wire

/* testbench/exu_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "exu_params.svh"

module exu_tb;

    logic clk, reset, flush;
    logic valid_in, ready_in, alt_in;
    logic valid_out, ready_out, pc_update;
    logic mem_wen, wb_wen;
    logic [2:0] funct3_in;
    exu_pkg::op_class_t op_class_in;
    exu_pkg::reg_addr_t rd_in, rs1_in, rs2_in, rd_out, mem_rd, wb_rd;
    exu_pkg::xword_t pc_in, src_a_in, src_b_in, imm_in;
    exu_pkg::xword_t pc_out, result, dnpc, mem_data, wb_data;

    // entries accepted by EX and not yet handed to MEM
    exu_pkg::ex_entry_t model_q[$];
    int errors = 0;
    int checks = 0;
    int accepted = 0;
    int retired = 0;
    int flushed = 0;
    int unsigned seed;

    exu_stage uut (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // MEM first, then WB, x0 never
    function automatic exu_pkg::xword_t fwd_operand(exu_pkg::reg_addr_t rs,
            exu_pkg::xword_t reg_val, logic used);
        if (used && rs != 0 && mem_wen && mem_rd == rs) begin
            return mem_data;
        end else if (used && rs != 0 && wb_wen && wb_rd == rs) begin
            return wb_data;
        end
        return reg_val;
    endfunction

    function automatic exu_pkg::xword_t expected_result(exu_pkg::ex_entry_t e,
            exu_pkg::xword_t a, exu_pkg::xword_t b);
        exu_pkg::xword_t s;
        logic [5:0] sh;
        s = (e.op_class == exu_pkg::OP_ALU_IMM) ? e.imm : b;
        sh = s[5:0];
        case (e.op_class)
            exu_pkg::OP_LUI:    return e.imm;
            exu_pkg::OP_AUIPC:  return e.pc + e.imm;
            // return address of a jump
            exu_pkg::OP_JAL,
            exu_pkg::OP_JALR:   return e.pc + `EXU_INST_BYTES;
            exu_pkg::OP_BRANCH: return '0;
            exu_pkg::OP_NONE:   return a + b;
            default: ;
        endcase
        case (e.funct3)
            3'd0: return (e.alt && e.op_class == exu_pkg::OP_ALU_REG) ? a - s : a + s;
            3'd1: return a << sh;
            3'd2: return ($signed(a) < $signed(s)) ? 64'd1 : 64'd0;
            3'd3: return (a < s) ? 64'd1 : 64'd0;
            3'd4: return a ^ s;
            3'd5: begin
                if (e.alt) begin
                    return $signed(a) >>> sh;
                end
                return a >> sh;
            end
            3'd6: return a | s;
            default: return a & s;
        endcase
    endfunction

    function automatic logic branch_taken(logic [2:0] f3, exu_pkg::xword_t a,
            exu_pkg::xword_t b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            3'd7: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    function automatic exu_pkg::xword_t expected_dnpc(exu_pkg::ex_entry_t e,
            exu_pkg::xword_t a);
        case (e.op_class)
            exu_pkg::OP_JAL, exu_pkg::OP_BRANCH: return e.pc + e.imm;
            exu_pkg::OP_JALR: return (a + e.imm) & ~64'd1;
            default: return e.pc + `EXU_INST_BYTES;
        endcase
    endfunction

    // small, small negative or full width
    function automatic exu_pkg::xword_t rand_word();
        case ($urandom % 4)
            0: return exu_pkg::xword_t'($urandom % 16);
            1: return -exu_pkg::xword_t'($urandom % 16);
            default: return {$urandom, $urandom};
        endcase
    endfunction

    task automatic check_word(string name, exu_pkg::xword_t actual,
            exu_pkg::xword_t expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("** Error at %0t: %s = %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic drive_random();
        exu_pkg::xword_t a;
        a = rand_word();
        valid_in    <= ($urandom % 5) != 0;
        ready_out   <= ($urandom % 4) != 0;
        flush       <= ($urandom % 40) == 0;
        pc_in       <= {$urandom, $urandom} & ~64'd3;
        op_class_in <= exu_pkg::op_class_t'($urandom % 8);
        funct3_in   <= $urandom % 8;
        alt_in      <= $urandom % 2;
        // narrow register range for frequent forwarding hits
        rd_in       <= $urandom % 8;
        rs1_in      <= $urandom % 8;
        rs2_in      <= $urandom % 8;
        src_a_in    <= a;
        src_b_in    <= (($urandom % 4) == 0) ? a : rand_word();
        imm_in      <= rand_word();
        mem_wen     <= $urandom % 2;
        mem_rd      <= $urandom % 8;
        mem_data    <= rand_word();
        wb_wen      <= $urandom % 2;
        wb_rd       <= $urandom % 8;
        wb_data     <= rand_word();
    endtask

    // outputs settle by the falling edge
    always @(negedge clk) begin
        exu_pkg::ex_entry_t head;
        exu_pkg::xword_t a;
        exu_pkg::xword_t b;
        logic exp_upd;
        logic uses_b;
        exp_upd = 1'b0;
        // nothing inside EX blocks
        check_word("ready_in", ready_in, ready_out);
        check_word("valid_out", valid_out, model_q.size() != 0);
        if (valid_out && model_q.size() != 0) begin
            head = model_q[0];
            uses_b = head.op_class == exu_pkg::OP_ALU_REG ||
                     head.op_class == exu_pkg::OP_BRANCH;
            a = fwd_operand(head.rs1, head.src_a, 1'b1);
            b = fwd_operand(head.rs2, head.src_b, uses_b);
            check_word("pc_out", pc_out, head.pc);
            check_word("rd_out", rd_out, head.rd);
            check_word("result", result, expected_result(head, a, b));
            check_word("dnpc", dnpc, expected_dnpc(head, a));
            exp_upd = ready_out && (head.op_class == exu_pkg::OP_JAL ||
                head.op_class == exu_pkg::OP_JALR ||
                (head.op_class == exu_pkg::OP_BRANCH && branch_taken(head.funct3, a, b)));
        end
        check_word("pc_update", pc_update, exp_upd);
        // bookkeeping for the coming rising edge
        // retired counts every handshake the DUT offers to MEM
        if (valid_out && ready_out) begin
            retired++;
            if (model_q.size() != 0) begin
                head = model_q.pop_front();
            end
        end
        if (reset || flush) begin
            flushed += model_q.size();
            model_q.delete();
        end else if (valid_in && ready_out) begin
            model_q.push_back('{pc: pc_in, op_class: op_class_in, funct3: funct3_in,
                alt: alt_in, rd: rd_in, rs1: rs1_in, rs2: rs2_in,
                src_a: src_a_in, src_b: src_b_in, imm: imm_in});
            accepted++;
        end
    end

    initial begin
        int timeout;
        int asrt_fails;
        seed = 14045;
        seed = $urandom(seed);
        reset = 1'b1;
        flush = 1'b0;
        valid_in = 1'b0;
        ready_out = 1'b1;
        pc_in = '0;
        op_class_in = exu_pkg::OP_NONE;
        funct3_in = '0;
        alt_in = 1'b0;
        rd_in = '0;
        rs1_in = '0;
        rs2_in = '0;
        src_a_in = '0;
        src_b_in = '0;
        imm_in = '0;
        mem_wen = 1'b0;
        mem_rd = '0;
        mem_data = '0;
        wb_wen = 1'b0;
        wb_rd = '0;
        wb_data = '0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        repeat (3000) begin
            @(posedge clk);
            drive_random();
        end
        // idle inputs, let the last entry leave
        @(posedge clk);
        valid_in <= 1'b0;
        ready_out <= 1'b1;
        flush <= 1'b0;
        timeout = 0;
        while ((model_q.size() != 0 || valid_out) && timeout < 100) begin
            @(posedge clk);
            timeout++;
        end
        if (timeout >= 100) begin
            errors++;
            $display("Timeout: the EX stage did not drain after stimulus ended");
        end
        if (accepted != retired + flushed) begin
            errors++;
            $display("Accepted entries were lost or duplicated on the way to MEM");
        end
        asrt_fails = uut.u_exu_assertions.failures;
        $display("checks %0d errors %0d assert fails %0d accepted %0d retired %0d flushed %0d",
                 checks, errors, asrt_fails, accepted, retired, flushed);
        if (errors == 0 && asrt_fails == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* exu_stage.f */
+incdir+rtl
rtl/exu_pkg.sv
rtl/exu_bypass_if.sv
rtl/ex_stage_reg.sv
rtl/operand_bypass.sv
rtl/alu_core.sv
rtl/branch_resolve.sv
rtl/exu_stage.sv
testbench/exu_assertions.sv
testbench/exu_tb.sv
